/* Bender.yml */
package:
  name: dcache

sources:
  - include_dirs:
      - src
    files:
      - src/dcache_pkg.sv
      - src/dcache_sram.sv
      - src/dcache_store_merge.sv
      - src/dcache_way.sv
      - src/dcache_ctrl.sv
      - src/dcache_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/dcache_assertions.sv
      - verification/dcache_tb.sv

/* dcache_top.f */
+incdir+src
src/dcache_pkg.sv
src/dcache_sram.sv
src/dcache_store_merge.sv
src/dcache_way.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verification/dcache_assertions.sv
verification/dcache_tb.sv

/* src/dcache_ctrl.sv */
////////////////////
// request buffer, miss FSM and per-set LRU bit
// one miss at a time, addr_ok low from MISS through REFILL
// store hits take one extra cycle in HIT_WRITE
////////////////////
`timescale 1ns/1ps

`include "dcache_defs.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    req_valid,
    input  mem_op_e req_op,
    input  logic [31:0] req_addr,
    input  word_t   req_wdata,
    input  strb_t   req_wstrb,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,
    output logic    rd_req,
    output logic [31:0] rd_addr,
    input  logic    rd_rdy,
    input  logic    ret_valid,
    input  line_t   ret_data,
    output logic    wr_req,
    output logic [31:0] wr_addr,
    output line_t   wr_data,
    input  logic    wr_rdy,
    // way control
    output index_t  ram_index,
    output tag_t    req_tag,
    output logic    way_bank_we [2][4],
    output logic    way_tag_we [2],
    output logic    dirty_we,
    output logic    dirty_val,
    input  logic    hit0, hit1, dirty0, dirty1, valid0, valid1,
    input  tag_t    tag0, tag1,
    input  line_t   line0, line1,
    // store merge
    output line_t   merge_base,
    output word_t   merge_word,
    output logic [1:0] merge_sel,
    output strb_t   merge_strb,
    input  line_t   merged_line
);

    cache_state_e state, next_state;

    // buffered request
    tag_t    buf_tag;
    index_t  buf_index;
    logic [1:0] buf_sel;
    mem_op_e buf_op;
    word_t   buf_wdata;
    strb_t   buf_wstrb;

    logic [`DCACHE_SETS-1:0] lru_bits;     // 1 = way1 is next victim
    logic  accept, hit_any, victim, victim_dirty;
    line_t hit_line;

    assign hit_any = hit0 | hit1;
    assign hit_line = hit1 ? line1 : line0;
    assign accept = req_valid && addr_ok;

    // an invalid way is filled before anything is evicted
    assign victim = !valid0 ? 1'b0 : (!valid1 ? 1'b1 : lru_bits[buf_index]);
    assign victim_dirty = victim ? dirty1 : dirty0;

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_tag   <= req_addr[31 -: `DCACHE_TAG_W];
            buf_index <= req_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
            buf_sel   <= req_addr[3:2];
            buf_op    <= req_op;
            buf_wdata <= req_wdata;
            buf_wstrb <= req_wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      if (accept) next_state = LOOKUP;
            LOOKUP: begin
                if (!hit_any)
                    next_state = MISS;
                else if (buf_op == OP_STORE)
                    next_state = HIT_WRITE;
                else
                    next_state = accept ? LOOKUP : IDLE;   // back-to-back hits
            end
            HIT_WRITE: next_state = IDLE;
            MISS:      if (!victim_dirty || wr_rdy) next_state = REPLACE;
            REPLACE:   if (rd_rdy) next_state = REFILL;
            REFILL:    if (ret_valid) next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    // lru points away from the way just used
    always_ff @(posedge clk) begin
        if (reset) begin
            lru_bits <= '0;
        end else if (state == LOOKUP && hit_any) begin
            lru_bits[buf_index] <= hit0;
        end else if (state == REFILL && ret_valid) begin
            lru_bits[buf_index] <= ~victim;
        end
    end

    assign addr_ok = (state == IDLE) || (state == LOOKUP && hit_any && buf_op == OP_LOAD);
    assign data_ok = (state == LOOKUP && hit_any) || (state == REFILL && ret_valid);
    assign rdata = (state == REFILL) ? ret_data[buf_sel*`DCACHE_WORD_W +: `DCACHE_WORD_W]
                                     : hit_line[buf_sel*`DCACHE_WORD_W +: `DCACHE_WORD_W];

    assign wr_req  = (state == MISS) && victim_dirty;
    assign wr_addr = {victim ? tag1 : tag0, buf_index, {`DCACHE_OFFSET_W{1'b0}}};
    assign wr_data = victim ? line1 : line0;
    assign rd_req  = (state == REPLACE);
    assign rd_addr = {buf_tag, buf_index, {`DCACHE_OFFSET_W{1'b0}}};   // line aligned

    // new request goes straight to the RAMs, else hold the buffered set
    assign ram_index = accept ? req_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W] : buf_index;
    assign req_tag = buf_tag;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_tag_we[w] = 1'b0;
            for (int b = 0; b < `DCACHE_WORDS; b++) begin
                way_bank_we[w][b] = 1'b0;
            end
        end
        if (state == HIT_WRITE) begin
            way_bank_we[hit1][buf_sel] = 1'b1;     // RAM still shows the hit set here
        end else if (state == REFILL && ret_valid) begin
            way_tag_we[victim] = 1'b1;
            for (int b = 0; b < `DCACHE_WORDS; b++) begin
                way_bank_we[victim][b] = 1'b1;
            end
        end
    end

    assign dirty_we  = (state == HIT_WRITE) || (state == REFILL && ret_valid);
    assign dirty_val = (buf_op == OP_STORE);

    // loads merge with an empty strobe so the refill line passes unchanged
    assign merge_base = (state == REFILL) ? ret_data : hit_line;
    assign merge_word = buf_wdata;
    assign merge_sel  = buf_sel;
    assign merge_strb = (buf_op == OP_STORE) ? buf_wstrb : '0;

endmodule

/* src/dcache_defs.svh */
////////////////////
// cache geometry for the two-way dcache
// tag + index + offset must add up to 32 address bits
// words per line times word width must equal the line width
////////////////////
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// physical address split
`define DCACHE_TAG_W     20
`define DCACHE_INDEX_W   8
`define DCACHE_OFFSET_W  4

`define DCACHE_SETS      256     // 2**DCACHE_INDEX_W

// data path
`define DCACHE_WORD_W    32
`define DCACHE_LINE_W    128
`define DCACHE_WORDS     4       // banks per way
`define DCACHE_STRB_W    4       // byte lanes per word

`endif

/* src/dcache_pkg.sv */
////////////////////
// types shared by the dcache blocks
// sizes come from the defs header
////////////////////
package dcache_pkg;

`include "dcache_defs.svh"

    // controller states, miss path runs MISS -> REPLACE -> REFILL
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT_WRITE,
        MISS,
        REPLACE,
        REFILL
    } cache_state_e;

    typedef enum logic {
        OP_LOAD,
        OP_STORE
    } mem_op_e;

    typedef logic [`DCACHE_TAG_W-1:0]   tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    typedef logic [`DCACHE_WORD_W-1:0]  word_t;
    typedef logic [`DCACHE_LINE_W-1:0]  line_t;
    typedef logic [`DCACHE_STRB_W-1:0]  strb_t;

endpackage

/* src/dcache_sram.sv */
////////////////////
// single-port RAM, one cycle read latency
// read-first on a write, contents undefined after power-up
////////////////////
`timescale 1ns/1ps

module dcache_sram #(
    parameter int data_width = 32,
    parameter int depth = 256
) (
    input  logic clk,
    input  logic we,
    input  logic [$clog2(depth)-1:0] addr,
    input  logic [data_width-1:0] wdata,
    output logic [data_width-1:0] rdata
);

    logic [data_width-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];     // old contents on a same-cycle write
    end

endmodule

/* src/dcache_store_merge.sv */
////////////////////
// byte-strobe merge of one store word into a line
// purely combinational, zero strobe returns the base line
////////////////////
`timescale 1ns/1ps

`include "dcache_defs.svh"

module dcache_store_merge
    import dcache_pkg::*;
(
    input  line_t      base,
    input  word_t      word,
    input  logic [1:0] sel,
    input  strb_t      strb,
    output line_t      merged
);

    always_comb begin
        merged = base;
        for (int b = 0; b < `DCACHE_STRB_W; b++) begin
            if (strb[b]) begin
                // byte b of the selected word
                merged[sel*`DCACHE_WORD_W + b*8 +: 8] = word[b*8 +: 8];
            end
        end
    end

endmodule

/* src/dcache_top.sv */
////////////////////
// two-way write-back dcache, physical addresses, all cacheable
// cpu side: valid / addr_ok / data_ok, in-order completion
// memory side: one 128-bit beat per refill or write-back
////////////////////
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    // cpu request / response
    input  logic    req_valid,
    input  mem_op_e req_op,
    input  logic [31:0] req_addr,
    input  word_t   req_wdata,
    input  strb_t   req_wstrb,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,
    // refill read
    output logic    rd_req,
    output logic [31:0] rd_addr,
    input  logic    rd_rdy,
    input  logic    ret_valid,
    input  line_t   ret_data,
    // victim write-back
    output logic    wr_req,
    output logic [31:0] wr_addr,
    output line_t   wr_data,
    input  logic    wr_rdy
);

    index_t ram_index;
    tag_t   req_tag;
    logic   way_bank_we [2][4];
    logic   way_tag_we [2];
    logic   dirty_we;
    logic   dirty_val;
    logic   hit0, hit1, dirty0, dirty1, valid0, valid1;
    tag_t   tag0, tag1;
    line_t  line0, line1;
    line_t  merge_base, merged_line;
    word_t  merge_word;
    logic [1:0] merge_sel;
    strb_t  merge_strb;

    dcache_ctrl u_ctrl (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_op(req_op), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_wstrb(req_wstrb),
        .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_data(ret_data),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_rdy(wr_rdy),
        .ram_index(ram_index), .req_tag(req_tag),
        .way_bank_we(way_bank_we), .way_tag_we(way_tag_we),
        .dirty_we(dirty_we), .dirty_val(dirty_val),
        .hit0(hit0), .hit1(hit1), .dirty0(dirty0), .dirty1(dirty1),
        .valid0(valid0), .valid1(valid1), .tag0(tag0), .tag1(tag1),
        .line0(line0), .line1(line1),
        .merge_base(merge_base), .merge_word(merge_word),
        .merge_sel(merge_sel), .merge_strb(merge_strb), .merged_line(merged_line)
    );

    dcache_way way0 (
        .clk(clk), .reset(reset), .ram_index(ram_index), .req_tag(req_tag),
        .bank_we(way_bank_we[0]), .tag_we(way_tag_we[0]),
        .dirty_we(dirty_we), .dirty_val(dirty_val), .wline(merged_line),
        .hit(hit0), .valid(valid0), .dirty(dirty0), .tag(tag0), .line(line0)
    );

    dcache_way way1 (
        .clk(clk), .reset(reset), .ram_index(ram_index), .req_tag(req_tag),
        .bank_we(way_bank_we[1]), .tag_we(way_tag_we[1]),
        .dirty_we(dirty_we), .dirty_val(dirty_val), .wline(merged_line),
        .hit(hit1), .valid(valid1), .dirty(dirty1), .tag(tag1), .line(line1)
    );

    dcache_store_merge u_merge (
        .base(merge_base), .word(merge_word), .sel(merge_sel),
        .strb(merge_strb), .merged(merged_line)
    );

endmodule

/* src/dcache_way.sv */
////////////////////
// one cache way: tag RAM, four word banks, valid and dirty flops
// outputs refer to the index presented one cycle earlier
// dirty_we is shared, a way updates dirty only on its own bank write
////////////////////
`timescale 1ns/1ps

`include "dcache_defs.svh"

module dcache_way
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  index_t ram_index,
    input  tag_t   req_tag,
    input  logic   bank_we [4],
    input  logic   tag_we,
    input  logic   dirty_we,
    input  logic   dirty_val,
    input  line_t  wline,
    output logic   hit,
    output logic   valid,
    output logic   dirty,
    output tag_t   tag,
    output line_t  line
);

    logic [`DCACHE_SETS-1:0] valid_bits;
    logic [`DCACHE_SETS-1:0] dirty_bits;
    index_t idx_q;        // index the RAM outputs belong to
    logic   bank_write;

    assign bank_write = bank_we[0] | bank_we[1] | bank_we[2] | bank_we[3];

    always_ff @(posedge clk) begin
        idx_q <= ram_index;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (tag_we) begin
                valid_bits[ram_index] <= 1'b1;
            end
            if (dirty_we && bank_write) begin
                dirty_bits[ram_index] <= dirty_val;
            end
        end
    end

    dcache_sram #(.data_width(`DCACHE_TAG_W), .depth(`DCACHE_SETS)) u_tag_ram (
        .clk(clk), .we(tag_we), .addr(ram_index), .wdata(req_tag), .rdata(tag)
    );

    for (genvar b = 0; b < `DCACHE_WORDS; b++) begin : g_bank
        dcache_sram #(.data_width(`DCACHE_WORD_W), .depth(`DCACHE_SETS)) u_bank (
            .clk(clk),
            .we(bank_we[b]),
            .addr(ram_index),
            .wdata(wline[b*`DCACHE_WORD_W +: `DCACHE_WORD_W]),
            .rdata(line[b*`DCACHE_WORD_W +: `DCACHE_WORD_W])
        );
    end

    assign valid = valid_bits[idx_q];
    assign dirty = dirty_bits[idx_q];
    assign hit   = valid && (tag == req_tag);   // req_tag is the buffered one

endmodule

/* verification/dcache_assertions.sv */
////////////////////
// concurrent checks on the dcache controller handshakes and FSM
// all checks are off while reset is high
// assumes one data_ok per accepted request
////////////////////
`timescale 1ns/1ps

module dcache_assertions
    import dcache_pkg::*;
(
    input logic         clk,
    input logic         reset,
    input cache_state_e state,
    input logic         req_valid,
    input logic         addr_ok,
    input logic         data_ok,
    input logic         rd_req,
    input logic         rd_rdy,
    input logic         ret_valid,
    input logic         wr_req,
    input logic         wr_rdy,
    input logic [31:0]  wr_addr,
    input line_t        wr_data
);

    int   fail_count = 0;
    int   outstanding;       // accepted requests not yet completed
    logic refill_pending;    // read accepted, return beat not yet seen

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(req_valid && addr_ok) - int'(data_ok);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            refill_pending <= 1'b0;
        end else if (rd_req && rd_rdy) begin
            refill_pending <= 1'b1;
        end else if (ret_valid) begin
            refill_pending <= 1'b0;
        end
    end

    // no second memory request while one is open
    a_one_request: assert property (@(posedge clk) disable iff (reset)
        !(rd_req && wr_req) && !(refill_pending && (rd_req || wr_req)))
        else begin
            $error("rd_req and wr_req overlap or a request was raised during a refill");
            fail_count++;
        end

    // an idle FSM owes no response
    a_no_idle_data_ok: assert property (@(posedge clk) disable iff (reset)
                                        state == IDLE |-> !data_ok && outstanding == 0)
        else begin
            $error("data_ok or an open request while the FSM is in IDLE");
            fail_count++;
        end

    // write-back request and payload held until accepted
    a_wr_held: assert property (@(posedge clk) disable iff (reset)
                                wr_req && !wr_rdy |=> wr_req && $stable(wr_addr)
                                                      && $stable(wr_data))
        else begin
            $error("write-back request dropped or changed before wr_rdy");
            fail_count++;
        end

endmodule

bind dcache_ctrl dcache_assertions u_checks (
    .clk(clk), .reset(reset), .state(state),
    .req_valid(req_valid), .addr_ok(addr_ok), .data_ok(data_ok),
    .rd_req(rd_req), .rd_rdy(rd_rdy), .ret_valid(ret_valid),
    .wr_req(wr_req), .wr_rdy(wr_rdy), .wr_addr(wr_addr), .wr_data(wr_data)
);

/* verification/dcache_tb.sv */
////////////////////
// dcache testbench driven by verification/dcache_vectors.txt
// memory model answers refills and write-backs after 0-5 random cycles
// a small set model predicts hits, victims and write-back lines
////////////////////
`timescale 1ns/1ps

`include "dcache_defs.svh"

module dcache_tb
    import dcache_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int TIMEOUT    = 200;
    localparam int MAX_VEC    = 64;

    logic        clk, reset;
    logic        req_valid;
    mem_op_e     req_op;
    logic [31:0] req_addr;
    word_t       req_wdata;
    strb_t       req_wstrb;
    logic        addr_ok, data_ok;
    word_t       rdata;
    logic        rd_req, rd_rdy, ret_valid;
    logic [31:0] rd_addr;
    line_t       ret_data;
    logic        wr_req, wr_rdy;
    logic [31:0] wr_addr;
    line_t       wr_data;

    logic [31:0] vec [MAX_VEC*5];    // op, addr, wdata, strb, expected
    int          num_vec;

    line_t mem_lines [logic [31:0]];   // memory after write-backs
    line_t ref_lines [logic [31:0]];   // memory as the cpu sees it
    tag_t  ref_tag   [2][`DCACHE_SETS];
    logic  ref_valid [2][`DCACHE_SETS];
    logic  ref_dirty [2][`DCACHE_SETS];
    logic  ref_lru   [`DCACHE_SETS];   // way to evict next

    dcache_top i_dcache_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // word i of line a holds a ^ (i * 0x11111111)
    function automatic line_t initial_line(input logic [31:0] line_addr);
        line_t l;
        for (int i = 0; i < `DCACHE_WORDS; i++) begin
            l[i*32 +: 32] = line_addr ^ (i * 32'h11111111);
        end
        return l;
    endfunction

    function automatic line_t memory_line(input logic [31:0] line_addr);
        return mem_lines.exists(line_addr) ? mem_lines[line_addr] : initial_line(line_addr);
    endfunction

    function automatic line_t expected_line(input logic [31:0] line_addr);
        return ref_lines.exists(line_addr) ? ref_lines[line_addr] : initial_line(line_addr);
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // outputs are settled a quarter period after the falling edge
    task automatic wait_sample();
        @(negedge clk);
        #(CLK_PERIOD/4);
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected)
            stop_on_error($sformatf("** Error: %s = %h, expected %h", name, actual, expected));
    endtask

    task automatic check_word(input logic expect_hit, input logic is_load, input word_t expected);
        int cycles;
        cycles = 0;
        while (!data_ok) begin
            if (expect_hit && (rd_req || wr_req))
                stop_on_error("memory request seen on an expected cache hit");
            cycles++;
            if (cycles > TIMEOUT)
                stop_on_error("no data_ok within 200 cycles");
            wait_sample();
        end
        if (is_load && rdata !== expected)
            stop_on_error($sformatf("** Error: rdata = %h, expected %h", rdata, expected));
        wait_sample();    // step past this pulse
    endtask

    task automatic check_addr(input logic is_write, input logic [31:0] expected);
        logic [31:0] actual;
        int cycles;
        cycles = 0;
        while (!(is_write ? wr_req : rd_req)) begin
            cycles++;
            if (cycles > TIMEOUT)
                stop_on_error(is_write ? "no write-back request within 200 cycles"
                                       : "no refill request within 200 cycles");
            wait_sample();
        end
        actual = is_write ? wr_addr : rd_addr;
        if (actual !== expected)
            stop_on_error($sformatf("** Error: %s = %h, expected %h",
                                    is_write ? "wr_addr" : "rd_addr", actual, expected));
    endtask

    task automatic check_line(input line_t expected);
        int cycles;
        cycles = 0;
        while (!wr_req) begin
            cycles++;
            if (cycles > TIMEOUT)
                stop_on_error("no write-back data within 200 cycles");
            wait_sample();
        end
        if (wr_data !== expected)
            stop_on_error($sformatf("** Error: wr_data = %h, expected %h", wr_data, expected));
    endtask

    task automatic drive_requests();
        int cycles;
        for (int i = 0; i < num_vec; i++) begin
            @(negedge clk);
            req_valid = 1'b1;
            req_op    = mem_op_e'(vec[5*i][0]);
            req_addr  = vec[5*i+1];
            req_wdata = vec[5*i+2];
            req_wstrb = vec[5*i+3][3:0];
            cycles = 0;
            #(CLK_PERIOD/4);
            while (!addr_ok) begin
                cycles++;
                if (cycles > TIMEOUT)
                    stop_on_error("request not accepted within 200 cycles");
                wait_sample();
            end
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // walks the vectors in order, predicting each one from the set model
    task automatic check_responses();
        logic [31:0] addr, line_addr, wb_addr;
        index_t idx;
        tag_t   tg;
        logic   hit, way, store;
        line_t  l;
        for (int i = 0; i < num_vec; i++) begin
            store     = vec[5*i][0];
            addr      = vec[5*i+1];
            line_addr = {addr[31:4], 4'h0};
            idx       = addr[11:4];
            tg        = addr[31:12];
            hit       = 1'b0;
            way       = ref_lru[idx];
            for (int w = 0; w < 2; w++) begin
                if (ref_valid[w][idx] && ref_tag[w][idx] == tg) begin
                    hit = 1'b1;
                    way = 1'(w);
                end
            end
            if (!hit) begin
                if (!ref_valid[0][idx])
                    way = 1'b0;    // empty way before lru
                else if (!ref_valid[1][idx])
                    way = 1'b1;
                if (ref_valid[way][idx] && ref_dirty[way][idx]) begin
                    wb_addr = {ref_tag[way][idx], idx, 4'h0};
                    check_addr(1'b1, wb_addr);
                    check_line(expected_line(wb_addr));
                end
                check_addr(1'b0, line_addr);
                ref_tag[way][idx]   = tg;
                ref_valid[way][idx] = 1'b1;
                ref_dirty[way][idx] = 1'b0;
            end
            ref_lru[idx] = ~way;
            if (store) begin
                l = expected_line(line_addr);
                for (int b = 0; b < 4; b++) begin
                    if (vec[5*i+3][b])
                        l[addr[3:2]*32 + b*8 +: 8] = vec[5*i+2][b*8 +: 8];
                end
                ref_lines[line_addr] = l;
                ref_dirty[way][idx]  = 1'b1;
            end
            check_word(hit, !store, vec[5*i+4]);
        end
    endtask

    initial begin : memory_model
        logic [31:0] line_addr;
        void'($urandom(51244));
        forever begin
            @(negedge clk);
            if (wr_req) begin
                repeat ($urandom_range(5)) @(negedge clk);
                wr_rdy = 1'b1;
                mem_lines[wr_addr] = wr_data;
                @(negedge clk);
                wr_rdy = 1'b0;
            end else if (rd_req) begin
                repeat ($urandom_range(5)) @(negedge clk);
                rd_rdy    = 1'b1;
                line_addr = rd_addr;
                @(negedge clk);
                rd_rdy = 1'b0;
                repeat ($urandom_range(5)) @(negedge clk);
                ret_data  = memory_line(line_addr);
                ret_valid = 1'b1;
                @(negedge clk);
                ret_valid = 1'b0;
            end
        end
    end

    always @(i_dcache_top.u_ctrl.u_checks.fail_count) begin
        if (i_dcache_top.u_ctrl.u_checks.fail_count != 0)
            stop_on_error("a concurrent assertion on the controller failed");
    end

    initial begin : main_sequence
        reset     = 1'b1;
        req_valid = 1'b0;
        req_op    = OP_LOAD;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        for (int s = 0; s < `DCACHE_SETS; s++) begin
            ref_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                ref_tag[w][s]   = '0;
                ref_valid[w][s] = 1'b0;
                ref_dirty[w][s] = 1'b0;
            end
        end
        $readmemh("verification/dcache_vectors.txt", vec);
        num_vec = 0;
        while (num_vec < MAX_VEC && !$isunknown(vec[5*num_vec]))
            num_vec++;
        if (num_vec == 0)
            stop_on_error("no vectors read from verification/dcache_vectors.txt");

        repeat (16) @(negedge clk);
        reset = 1'b0;
        #(CLK_PERIOD/4);
        check_flag("addr_ok", addr_ok, 1'b1);
        check_flag("data_ok", data_ok, 1'b0);
        check_flag("rd_req", rd_req, 1'b0);
        check_flag("wr_req", wr_req, 1'b0);

        fork
            drive_requests();
            check_responses();
        join

        if (i_dcache_top.u_ctrl.u_checks.fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1, "concurrent assertions failed during the run");
        end
    end

endmodule

/* verification/dcache_vectors.txt */
// op addr wdata strb expected_rdata, all hex
// op 0 is a load, 1 a store; stores carry 0 as expected data
// load miss, then a hit in the same line
0 00001004 00000000 0 11110111
0 00001008 00000000 0 22223222
// partial stores, first a miss then a hit, each read back
1 0000201c aabbccdd 5 00000000
0 0000201c 00000000 0 33bb13dd
1 00002014 12345678 a 00000000
0 00002014 00000000 0 12115601
// three lines in set 3, the dirty one is evicted and reloaded
1 00010030 cafef00d f 00000000
0 00020034 00000000 0 11131121
0 00030038 00000000 0 22212212
0 00010030 00000000 0 cafef00d
0 00010034 00000000 0 11101121
// back-to-back loads with one miss in the middle
0 00001000 00000000 0 00001000
0 0000100c 00000000 0 33332333
0 00002018 00000000 0 22220232
0 0003003c 00000000 0 33303303
0 00010038 00000000 0 22232212
0 00040040 00000000 0 00040040
0 00040044 00000000 0 11151151
0 0000201c 00000000 0 33bb13dd
0 00001004 00000000 0 11110111
